// File: Makefile
# Verilator build and run of the pcxt_glue testbench

VERILATOR ?= verilator
TOP       ?= tb_pcxt_glue
LOG       ?= sim.log
FILELIST  ?= pcxt_glue.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timescale 1ns/1ps

PASS_TEXT := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the simulator
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/pcxt_macros.svh
`ifndef PCXT_MACROS_SVH
`define PCXT_MACROS_SVH

// bus widths
`define PCXT_BIOS_ADDR_BITS 20
`define PCXT_IOCTL_ADDR_BITS 25
`define PCXT_BYTE_BITS 8
`define PCXT_PROTECT_BITS 2
`define PCXT_MAIN_OFFSET_BITS 16
`define PCXT_XTIDE_OFFSET_BITS 14

// reset timing, in clk_chipset cycles
`define PCXT_RESET_HOLD_CYCLES 65535
`define PCXT_CPU_RESET_DELAY 43

// BIOS write strobe timing
`define PCXT_WRITE_PULSE_CYCLES 20
`define PCXT_WRITE_RECOVER_CYCLES 21

// download indexes and BIOS placement
`define PCXT_TANDY_INDEX 2
`define PCXT_XTIDE_INDEX 3
`define PCXT_MAIN_BIOS_PAGE 4'hF
`define PCXT_XTIDE_BIOS_PAGE 6'b111011
`define PCXT_IDLE_ADDRESS 20'hFFFFF

`endif

// File: pcxt_glue.f
+incdir+include
verilog/pcxt_pkg.sv
verilog/reset_sequencer.sv
verilog/cpu_speed_select.sv
verilog/bios_address_map.sv
verilog/bios_loader.sv
verilog/pcxt_glue.sv
tb/tb_clock.sv
tb/tb_pcxt_glue.sv

// File: tb/tb_clock.sv
module tb_clock
(
    output logic clk_chipset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    localparam int HALF_PERIOD_NS = 2;

    initial
    begin
        clk_chipset = 1'b0;
        forever
            #(HALF_PERIOD_NS) clk_chipset = ~clk_chipset;
    end

endmodule

// File: tb/tb_pcxt_glue.sv
`include "pcxt_macros.svh"

module tb_pcxt_glue;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD_NS   = 4;
    localparam int HOLD_CYCLES       = 64;
    localparam int RESET_FALL_CYCLES = HOLD_CYCLES + 1;
    localparam int CPU_DELAY_CYCLES  = 43;
    localparam int WRITE_LOW_CYCLES  = 20;
    localparam int RECOVER_CYCLES    = 21;
    localparam int QUIET_CYCLES      = 24;
    localparam int SLACK             = 8;

    // wait limits are twice the expected delay plus slack
    localparam int SYS_LIMIT     = 2 * RESET_FALL_CYCLES + SLACK;
    localparam int CPU_LIMIT     = 2 * CPU_DELAY_CYCLES + SLACK;
    localparam int STEP_LIMIT    = 2 + SLACK;
    localparam int STROBE_LIMIT  = 2 * WRITE_LOW_CYCLES + SLACK;
    localparam int RECOVER_LIMIT = 2 * RECOVER_CYCLES + SLACK;
    localparam int BYTE_CYCLES   = 2 * RECOVER_LIMIT + 1 + STEP_LIMIT + STROBE_LIMIT;
    localparam int TEST_CYCLES   = (5 + SYS_LIMIT + CPU_LIMIT) + (2 + SYS_LIMIT + CPU_LIMIT)
                                   + (1 + 2 * STEP_LIMIT) + 3 * BYTE_CYCLES
                                   + (5 + QUIET_CYCLES + SLACK + SYS_LIMIT + CPU_LIMIT) + 16;
    localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLOCK_PERIOD_NS;

    // output selectors for the delay measurement
    localparam int SIG_RESET_SYSTEM   = 0;
    localparam int SIG_RESET_CPU      = 1;
    localparam int SIG_IOCTL_WAIT     = 2;
    localparam int SIG_WRITE_N        = 3;
    localparam int SIG_ACCESS_REQUEST = 4;

    logic                             clk_chipset;
    logic                             reset;
    logic                             ioctl_download;
    logic [`PCXT_BYTE_BITS-1:0]       ioctl_index;
    logic [`PCXT_IOCTL_ADDR_BITS-1:0] ioctl_addr;
    logic [`PCXT_BYTE_BITS-1:0]       ioctl_data;
    logic                             ioctl_wr;
    logic                             reset_request;
    logic [1:0]                       bios_writable;
    logic                             model_tandy;
    logic [1:0]                       speed_option;
    logic [1:0]                       xtctl_speed;
    logic                             memory_ready;
    logic                             processor_ready;
    logic                             address_direction;
    logic                             biu_done;
    logic                             reset_system;
    logic                             reset_cpu;
    logic                             ioctl_wait;
    pcxt_pkg::bios_addr_t             bios_address;
    logic [`PCXT_BYTE_BITS-1:0]       bios_write_data;
    logic                             bios_write_n;
    logic                             bios_access_request;
    logic [1:0]                       bios_protect_flag;
    logic                             tandy_bios_flag;
    logic                             turbo_mode;
    pcxt_pkg::cpu_speed_t             clk_select;

    int          check_errors = 0;
    int          other_errors = 0;
    logic [31:0] lfsr_state   = 32'hf555c3c6;

    tb_clock u_clock (.clk_chipset(clk_chipset));

    pcxt_glue #(.RESET_HOLD_CYCLES(HOLD_CYCLES)) DUT (.*);

    ////////////////////
    // random source
    ////////////////////

    // fibonacci, taps 32 22 2 1
    function automatic logic lfsr_next_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
            value = {value[30:0], lfsr_next_bit()};
        return value;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            check_errors++;
            $display("CHECK FAILED time %0t %s expected %b actual %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected)
        begin
            check_errors++;
            $display("CHECK FAILED time %0t %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_address(input string name, input pcxt_pkg::bios_addr_t expected,
                                 input pcxt_pkg::bios_addr_t actual);
        if (actual !== expected)
        begin
            check_errors++;
            $display("CHECK FAILED time %0t %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_speed(input string name, input pcxt_pkg::cpu_speed_t expected,
                               input pcxt_pkg::cpu_speed_t actual);
        if (actual !== expected)
        begin
            check_errors++;
            $display("CHECK FAILED time %0t %s expected %s actual %s (%b)",
                     $time, name, expected.name(), actual.name(), actual);
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] expected,
                               input logic [1:0] actual);
        if (actual !== expected)
        begin
            check_errors++;
            $display("CHECK FAILED time %0t %s expected %b actual %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            check_errors++;
            $display("CHECK FAILED time %0t %s delay expected %0d cycles actual %0d cycles",
                     $time, name, expected, actual);
        end
    endtask

    function automatic logic sample_output(input int which);
        case (which)
            SIG_RESET_SYSTEM:   return reset_system;
            SIG_RESET_CPU:      return reset_cpu;
            SIG_IOCTL_WAIT:     return ioctl_wait;
            SIG_WRITE_N:        return bios_write_n;
            SIG_ACCESS_REQUEST: return bios_access_request;
            default:            return 1'bx;
        endcase
    endfunction

    // counts falling edges until the output reaches level
    task automatic expect_delay(input int which, input string name, input logic level,
                                input int expected);
        int   limit;
        int   count;
        logic found;
        limit = 2 * expected + SLACK;
        count = 0;
        found = 1'b0;
        while (!found && count < limit)
        begin
            @(negedge clk_chipset);
            count++;
            found = (sample_output(which) === level);
        end
        if (found)
            check_cycles(name, expected, count);
        else
        begin
            other_errors++;
            $display("timeout: %s did not go to %b within %0d cycles", name, level, limit);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reset_release();
        repeat (4) @(negedge clk_chipset);
        check_bit("reset_system", 1'b1, reset_system);
        check_bit("reset_cpu", 1'b1, reset_cpu);
        reset = 1'b0;
        expect_delay(SIG_RESET_SYSTEM, "reset_system", 1'b0, RESET_FALL_CYCLES);
        expect_delay(SIG_RESET_CPU, "reset_cpu", 1'b0, CPU_DELAY_CYCLES);
        check_bit("bios_write_n", 1'b1, bios_write_n);
        check_bit("turbo_mode", 1'b0, turbo_mode);
        check_bit("bios_access_request", 1'b0, bios_access_request);
        check_flags("bios_protect_flag", ~bios_writable, bios_protect_flag);
        // model was high during reset, so the later change must not show
        model_tandy = 1'b0;
        @(negedge clk_chipset);
        check_bit("tandy_bios_flag", 1'b1, tandy_bios_flag);
    endtask

    task automatic reset_request_pulse();
        reset_request = 1'b1;
        @(negedge clk_chipset);
        check_bit("reset_system", 1'b1, reset_system);
        check_bit("reset_cpu", 1'b1, reset_cpu);
        reset_request = 1'b0;
        expect_delay(SIG_RESET_SYSTEM, "reset_system", 1'b0, RESET_FALL_CYCLES);
        expect_delay(SIG_RESET_CPU, "reset_cpu", 1'b0, CPU_DELAY_CYCLES);
        check_bit("tandy_bios_flag", 1'b0, tandy_bios_flag);
    endtask

    task automatic start_download();
        ioctl_index       = 8'd0;
        ioctl_addr        = '0;
        ioctl_download    = 1'b1;
        processor_ready   = 1'b0;
        address_direction = 1'b1;
        expect_delay(SIG_IOCTL_WAIT, "ioctl_wait", 1'b1, 1);
        check_bit("bios_access_request", 1'b1, bios_access_request);
        expect_delay(SIG_IOCTL_WAIT, "ioctl_wait", 1'b0, 1);
        check_flags("bios_protect_flag", 2'b00, bios_protect_flag);
    endtask

    // one byte through the port, then the strobe and recovery timing
    task automatic load_byte(input logic [7:0] index, input logic [24:0] addr,
                             input logic [7:0] data, input pcxt_pkg::bios_addr_t expected,
                             input logic tandy_flag);
        repeat (RECOVER_LIMIT)
            if (ioctl_wait)
                @(negedge clk_chipset);
        if (ioctl_wait)
        begin
            other_errors++;
            $display("ioctl_wait stayed high, byte could not be presented");
        end
        ioctl_index = index;
        ioctl_addr  = addr;
        ioctl_data  = data;
        ioctl_wr    = 1'b1;
        @(negedge clk_chipset);
        ioctl_wr = 1'b0;
        check_bit("ioctl_wait", 1'b1, ioctl_wait);
        expect_delay(SIG_WRITE_N, "bios_write_n", 1'b0, 1);
        check_address("bios_address", expected, bios_address);
        check_byte("bios_write_data", data, bios_write_data);
        check_flags("bios_protect_flag", 2'b00, bios_protect_flag);
        check_bit("bios_access_request", 1'b1, bios_access_request);
        check_bit("reset_system", 1'b1, reset_system);
        check_bit("tandy_bios_flag", tandy_flag, tandy_bios_flag);
        expect_delay(SIG_WRITE_N, "bios_write_n", 1'b1, WRITE_LOW_CYCLES);
        check_bit("tandy_bios_flag", model_tandy, tandy_bios_flag);
        expect_delay(SIG_IOCTL_WAIT, "ioctl_wait", 1'b0, RECOVER_CYCLES);
    endtask

    task automatic pcxt_byte_load();
        logic [15:0] offset;
        logic [7:0]  data;
        offset = 16'(random_bits(16));
        data   = 8'(random_bits(8));
        start_download();
        load_byte(8'd0, {9'd0, offset}, data, {4'hF, offset}, 1'b0);
    endtask

    task automatic xtide_and_tandy_loads();
        logic [24:0] addr;
        logic [15:0] offset;
        logic [7:0]  data;
        addr = 25'(random_bits(25));
        data = 8'(random_bits(8));
        load_byte(8'd3, addr, data, {6'b111011, addr[13:0]}, 1'b0);
        offset = 16'(random_bits(16));
        data   = 8'(random_bits(8));
        load_byte(8'd2, {9'd0, offset}, data, {4'hF, offset}, 1'b1);
    endtask

    task automatic ignored_byte_and_end();
        logic saw_strobe;
        logic saw_wait;
        saw_strobe  = 1'b0;
        saw_wait    = 1'b0;
        // bit 16 set puts the byte outside a 64K image
        ioctl_index = 8'd0;
        ioctl_addr  = {8'd0, 1'b1, 16'(random_bits(16))};
        ioctl_data  = 8'(random_bits(8));
        ioctl_wr    = 1'b1;
        @(negedge clk_chipset);
        ioctl_wr = 1'b0;
        repeat (QUIET_CYCLES)
        begin
            saw_strobe |= !bios_write_n;
            saw_wait   |= ioctl_wait;
            @(negedge clk_chipset);
        end
        check_bit("bios_write_n low after ignored byte", 1'b0, saw_strobe);
        check_bit("ioctl_wait high after ignored byte", 1'b0, saw_wait);
        ioctl_download    = 1'b0;
        processor_ready   = 1'b1;
        address_direction = 1'b0;
        expect_delay(SIG_ACCESS_REQUEST, "bios_access_request", 1'b0, 2);
        check_flags("bios_protect_flag", ~bios_writable, bios_protect_flag);
        expect_delay(SIG_RESET_SYSTEM, "reset_system", 1'b0, RESET_FALL_CYCLES);
        expect_delay(SIG_RESET_CPU, "reset_cpu", 1'b0, CPU_DELAY_CYCLES);
    endtask

    task automatic pulse_biu_done();
        biu_done = 1'b1;
        @(negedge clk_chipset);
        biu_done = 1'b0;
    endtask

    task automatic speed_selection();
        speed_option = 2'd2;
        xtctl_speed  = 2'd0;
        repeat (3) @(negedge clk_chipset);
        check_speed("clk_select", pcxt_pkg::SPEED_4_77, clk_select);
        check_bit("turbo_mode", 1'b0, turbo_mode);
        pulse_biu_done();
        check_speed("clk_select", pcxt_pkg::SPEED_14_318, clk_select);
        check_bit("turbo_mode", 1'b1, turbo_mode);
        // override only lands on the next bus cycle end
        xtctl_speed = 2'd2;
        repeat (3) @(negedge clk_chipset);
        check_speed("clk_select", pcxt_pkg::SPEED_14_318, clk_select);
        pulse_biu_done();
        check_speed("clk_select", pcxt_pkg::SPEED_7_16, clk_select);
        check_bit("turbo_mode", 1'b1, turbo_mode);
        xtctl_speed = 2'd1;
        pulse_biu_done();
        check_speed("clk_select", pcxt_pkg::SPEED_4_77, clk_select);
        check_bit("turbo_mode", 1'b0, turbo_mode);
    endtask

    task automatic finish_run();
        $display("check failures: %0d, other failures: %0d", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial
    begin
        reset             = 1'b1;
        ioctl_download    = 1'b0;
        ioctl_index       = '0;
        ioctl_addr        = '0;
        ioctl_data        = '0;
        ioctl_wr          = 1'b0;
        reset_request     = 1'b0;
        bios_writable     = 2'b01;
        model_tandy       = 1'b1;
        speed_option      = 2'd0;
        xtctl_speed       = 2'd0;
        memory_ready      = 1'b1;
        processor_ready   = 1'b1;
        address_direction = 1'b0;
        biu_done          = 1'b0;
        reset_release();
        reset_request_pulse();
        pcxt_byte_load();
        xtide_and_tandy_loads();
        ignored_byte_and_end();
        speed_selection();
        finish_run();
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        finish_run();
    end

endmodule

// File: verilog/bios_address_map.sv
`include "pcxt_macros.svh"

module bios_address_map
(
    input  logic [`PCXT_BYTE_BITS-1:0]       ioctl_index,
    input  logic [`PCXT_IOCTL_ADDR_BITS-1:0] ioctl_addr,
    input  logic                             ioctl_download,
    output pcxt_pkg::bios_image_t            image,
    output pcxt_pkg::bios_addr_t             mapped_address
);

    logic within_64k;

    // main images are at most 64K long
    assign within_64k = (ioctl_addr[`PCXT_IOCTL_ADDR_BITS-1:`PCXT_MAIN_OFFSET_BITS] == '0);

    always_comb
    begin
        if (!ioctl_download)
            image = pcxt_pkg::IMAGE_NONE;
        else if ((ioctl_index[5:0] < 6'(`PCXT_TANDY_INDEX)) && within_64k)
            image = pcxt_pkg::IMAGE_PCXT;
        else if ((ioctl_index[5:0] == 6'(`PCXT_TANDY_INDEX)) && within_64k)
            image = pcxt_pkg::IMAGE_TANDY;
        else if (ioctl_index == `PCXT_BYTE_BITS'(`PCXT_XTIDE_INDEX))
            image = pcxt_pkg::IMAGE_XTIDE;
        else
            image = pcxt_pkg::IMAGE_NONE;
    end

    always_comb
    begin
        mapped_address = `PCXT_IDLE_ADDRESS;
        case (image)
            pcxt_pkg::IMAGE_PCXT, pcxt_pkg::IMAGE_TANDY:
            begin
                mapped_address.main.page   = `PCXT_MAIN_BIOS_PAGE;
                mapped_address.main.offset = ioctl_addr[`PCXT_MAIN_OFFSET_BITS-1:0];
            end
            pcxt_pkg::IMAGE_XTIDE:
            begin
                mapped_address.xtide.page   = `PCXT_XTIDE_BIOS_PAGE;
                mapped_address.xtide.offset = ioctl_addr[`PCXT_XTIDE_OFFSET_BITS-1:0];
            end
            default:
                mapped_address = `PCXT_IDLE_ADDRESS;
        endcase
    end

endmodule

// File: verilog/bios_loader.sv
`include "pcxt_macros.svh"

module bios_loader
(
    input  logic                          clk_chipset,
    input  logic                          reset,
    input  logic                          memory_ready,
    input  logic                          ioctl_download,
    input  logic                          ioctl_wr,
    input  logic [`PCXT_BYTE_BITS-1:0]    ioctl_data,
    input  pcxt_pkg::bios_image_t         image,
    input  pcxt_pkg::bios_addr_t          mapped_address,
    input  logic                          processor_ready,
    input  logic                          address_direction,
    input  logic [`PCXT_PROTECT_BITS-1:0] bios_writable,
    input  logic                          tandy_mode,
    output logic                          ioctl_wait,
    output logic                          bios_access_request,
    output pcxt_pkg::bios_addr_t          bios_address,
    output logic [`PCXT_BYTE_BITS-1:0]    bios_write_data,
    output logic                          bios_write_n,
    output logic [`PCXT_PROTECT_BITS-1:0] bios_protect_flag,
    output logic                          tandy_bios_flag
);

    // last count value of a write plus its recovery
    localparam int CYCLE_LAST = `PCXT_WRITE_PULSE_CYCLES + `PCXT_WRITE_RECOVER_CYCLES - 1;
    localparam int CNT_BITS   = $clog2(CYCLE_LAST + 1);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WAIT_DATA = 2'd1;
    localparam logic [1:0] ST_WRITE     = 2'd2;
    localparam logic [1:0] ST_RECOVER   = 2'd3;

    logic [1:0]          state;
    logic [CNT_BITS-1:0] cycle_count;
    logic                tandy_bios_write;
    logic                byte_accept;

    assign byte_accept = (state == ST_WAIT_DATA) && ioctl_download && ioctl_wr
                         && (image != pcxt_pkg::IMAGE_NONE);

    // outside a strobe the chipset sees the latched model
    assign tandy_bios_flag = bios_write_n ? tandy_mode : tandy_bios_write;

    always_ff @(posedge clk_chipset)
    begin
        if (byte_accept)
            bios_write_data <= ioctl_data;
    end

    ////////////////////
    // load FSM
    ////////////////////

    always_ff @(posedge clk_chipset or posedge reset)
    begin
        if (reset)
        begin
            state               <= ST_IDLE;
            cycle_count         <= '0;
            ioctl_wait          <= 1'b1;
            bios_access_request <= 1'b0;
            bios_write_n        <= 1'b1;
            bios_protect_flag   <= '1;
            bios_address        <= `PCXT_IDLE_ADDRESS;
            tandy_bios_write    <= 1'b0;
        end
        else if (!memory_ready)
        begin
            // SDRAM still initializing, hold the host off
            state               <= ST_IDLE;
            cycle_count         <= '0;
            ioctl_wait          <= 1'b1;
            bios_access_request <= 1'b0;
            bios_write_n        <= 1'b1;
            bios_protect_flag   <= '1;
            bios_address        <= `PCXT_IDLE_ADDRESS;
            tandy_bios_write    <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    bios_protect_flag   <= ~bios_writable;
                    bios_address        <= `PCXT_IDLE_ADDRESS;
                    bios_write_n        <= 1'b1;
                    cycle_count         <= '0;
                    // request keeps the system in reset while loading
                    bios_access_request <= ioctl_download;
                    ioctl_wait          <= ioctl_download;
                    // wait until the CPU is off the bus
                    if (ioctl_download && !processor_ready && address_direction)
                        state <= ST_WAIT_DATA;
                end
                ST_WAIT_DATA:
                begin
                    bios_protect_flag   <= '0;
                    bios_access_request <= 1'b1;
                    if (!ioctl_download)
                    begin
                        ioctl_wait <= 1'b0;
                        state      <= ST_IDLE;
                    end
                    else if (byte_accept)
                    begin
                        bios_address     <= mapped_address;
                        tandy_bios_write <= (image == pcxt_pkg::IMAGE_TANDY);
                        ioctl_wait       <= 1'b1;
                        cycle_count      <= '0;
                        state            <= ST_WRITE;
                    end
                    else
                        ioctl_wait <= 1'b0;
                end
                ST_WRITE:
                begin
                    cycle_count <= cycle_count + CNT_BITS'(1);
                    if (cycle_count != CNT_BITS'(`PCXT_WRITE_PULSE_CYCLES))
                        bios_write_n <= 1'b0;
                    else
                    begin
                        bios_write_n <= 1'b1;
                        bios_address <= `PCXT_IDLE_ADDRESS;
                        state        <= ST_RECOVER;
                    end
                end
                default:
                begin
                    // let the SDRAM write finish before the next byte
                    cycle_count <= cycle_count + CNT_BITS'(1);
                    if (cycle_count == CNT_BITS'(CYCLE_LAST))
                        state <= ST_WAIT_DATA;
                end
            endcase
        end
    end

endmodule

// File: verilog/cpu_speed_select.sv
module cpu_speed_select
(
    input  logic                 clk_chipset,
    input  logic                 reset_system,
    input  logic                 biu_done,
    input  logic [1:0]           speed_option,
    input  logic [1:0]           xtctl_speed,
    output logic                 turbo_mode,
    output pcxt_pkg::cpu_speed_t clk_select
);

    pcxt_pkg::cpu_speed_t next_speed;

    // xtctl value 0 means no override, 1..3 pick a speed
    always_comb
    begin
        if (xtctl_speed != 2'b00)
            next_speed = pcxt_pkg::cpu_speed_t'(xtctl_speed - 2'd1);
        else
            next_speed = pcxt_pkg::cpu_speed_t'(speed_option);
    end

    // only between bus cycles, never in the middle of one
    always_ff @(posedge clk_chipset or posedge reset_system)
    begin
        if (reset_system)
        begin
            clk_select <= pcxt_pkg::SPEED_4_77;
            turbo_mode <= 1'b0;
        end
        else if (biu_done)
        begin
            clk_select <= next_speed;
            turbo_mode <= (next_speed != pcxt_pkg::SPEED_4_77);
        end
    end

endmodule

// File: verilog/pcxt_glue.sv
`include "pcxt_macros.svh"

module pcxt_glue
#(
    parameter int RESET_HOLD_CYCLES = `PCXT_RESET_HOLD_CYCLES
)
(
    input  logic                               clk_chipset,
    input  logic                               reset,
    // download port
    input  logic                               ioctl_download,
    input  logic [`PCXT_BYTE_BITS-1:0]         ioctl_index,
    input  logic [`PCXT_IOCTL_ADDR_BITS-1:0]   ioctl_addr,
    input  logic [`PCXT_BYTE_BITS-1:0]         ioctl_data,
    input  logic                               ioctl_wr,
    // options
    input  logic                               reset_request,
    input  logic [`PCXT_PROTECT_BITS-1:0]      bios_writable,
    input  logic                               model_tandy,
    input  logic [1:0]                         speed_option,
    input  logic [1:0]                         xtctl_speed,
    // memory and bus status
    input  logic                               memory_ready,
    input  logic                               processor_ready,
    input  logic                               address_direction,
    input  logic                               biu_done,
    // resets
    output logic                               reset_system,
    output logic                               reset_cpu,
    // BIOS write side
    output logic                               ioctl_wait,
    output pcxt_pkg::bios_addr_t               bios_address,
    output logic [`PCXT_BYTE_BITS-1:0]         bios_write_data,
    output logic                               bios_write_n,
    output logic                               bios_access_request,
    output logic [`PCXT_PROTECT_BITS-1:0]      bios_protect_flag,
    output logic                               tandy_bios_flag,
    // speed
    output logic                               turbo_mode,
    output pcxt_pkg::cpu_speed_t               clk_select
);

    logic                  tandy_mode;
    pcxt_pkg::bios_image_t image;
    pcxt_pkg::bios_addr_t  mapped_address;

    reset_sequencer #(
        .HOLD_CYCLES         (RESET_HOLD_CYCLES)
    ) u_reset_sequencer (
        .clk_chipset         (clk_chipset),
        .reset               (reset),
        .reset_request       (reset_request),
        .bios_access_request (bios_access_request),
        .model_tandy         (model_tandy),
        .reset_system        (reset_system),
        .reset_cpu           (reset_cpu),
        .tandy_mode          (tandy_mode)
    );

    cpu_speed_select u_cpu_speed_select (
        .clk_chipset         (clk_chipset),
        .reset_system        (reset_system),
        .biu_done            (biu_done),
        .speed_option        (speed_option),
        .xtctl_speed         (xtctl_speed),
        .turbo_mode          (turbo_mode),
        .clk_select          (clk_select)
    );

    bios_address_map u_bios_address_map (
        .ioctl_index         (ioctl_index),
        .ioctl_addr          (ioctl_addr),
        .ioctl_download      (ioctl_download),
        .image               (image),
        .mapped_address      (mapped_address)
    );

    bios_loader u_bios_loader (
        .clk_chipset         (clk_chipset),
        .reset               (reset),
        .memory_ready        (memory_ready),
        .ioctl_download      (ioctl_download),
        .ioctl_wr            (ioctl_wr),
        .ioctl_data          (ioctl_data),
        .image               (image),
        .mapped_address      (mapped_address),
        .processor_ready     (processor_ready),
        .address_direction   (address_direction),
        .bios_writable       (bios_writable),
        .tandy_mode          (tandy_mode),
        .ioctl_wait          (ioctl_wait),
        .bios_access_request (bios_access_request),
        .bios_address        (bios_address),
        .bios_write_data     (bios_write_data),
        .bios_write_n        (bios_write_n),
        .bios_protect_flag   (bios_protect_flag),
        .tandy_bios_flag     (tandy_bios_flag)
    );

endmodule

// File: verilog/pcxt_pkg.sv
`include "pcxt_macros.svh"

package pcxt_pkg;

    ////////////////////
    // BIOS address views
    ////////////////////

    // PC/XT and Tandy images, 64K page at F0000
    typedef struct packed
    {
        logic [`PCXT_BIOS_ADDR_BITS-`PCXT_MAIN_OFFSET_BITS-1:0] page;
        logic [`PCXT_MAIN_OFFSET_BITS-1:0]                      offset;
    } bios_main_view_t;

    // XT-IDE option ROM, 16K page at EC000
    typedef struct packed
    {
        logic [`PCXT_BIOS_ADDR_BITS-`PCXT_XTIDE_OFFSET_BITS-1:0] page;
        logic [`PCXT_XTIDE_OFFSET_BITS-1:0]                      offset;
    } bios_xtide_view_t;

    typedef union packed
    {
        bios_main_view_t  main;
        bios_xtide_view_t xtide;
    } bios_addr_t;

    ////////////////////
    // option encodings
    ////////////////////

    typedef enum logic [1:0]
    {
        IMAGE_NONE  = 2'd0,
        IMAGE_PCXT  = 2'd1,
        IMAGE_TANDY = 2'd2,
        IMAGE_XTIDE = 2'd3
    } bios_image_t;

    // matches the clock mux select of the chipset
    typedef enum logic [1:0]
    {
        SPEED_4_77   = 2'd0,
        SPEED_7_16   = 2'd1,
        SPEED_14_318 = 2'd2
    } cpu_speed_t;

endpackage

// File: verilog/reset_sequencer.sv
`include "pcxt_macros.svh"

module reset_sequencer
#(
    parameter int HOLD_CYCLES = `PCXT_RESET_HOLD_CYCLES
)
(
    input  logic clk_chipset,
    input  logic reset,
    input  logic reset_request,
    input  logic bios_access_request,
    input  logic model_tandy,
    output logic reset_system,
    output logic reset_cpu,
    output logic tandy_mode
);

    localparam int HOLD_BITS  = $clog2(HOLD_CYCLES + 1);
    localparam int DELAY_BITS = $clog2(`PCXT_CPU_RESET_DELAY);

    logic                  reset_cause;
    logic [HOLD_BITS-1:0]  hold_count;
    logic [DELAY_BITS-1:0] cpu_delay_count;

    // board reset, menu reset, or a BIOS load in progress
    assign reset_cause = reset | reset_request | bios_access_request;

    ////////////////////
    // system reset stretch
    ////////////////////

    // count restarts from zero every time a cause fires
    always_ff @(posedge clk_chipset or posedge reset_cause)
    begin
        if (reset_cause)
        begin
            reset_system <= 1'b1;
            hold_count   <= '0;
        end
        else if (reset_system)
        begin
            if (hold_count != HOLD_BITS'(HOLD_CYCLES))
                hold_count <= hold_count + HOLD_BITS'(1);
            else
                reset_system <= 1'b0;
        end
    end

    ////////////////////
    // CPU reset delay
    ////////////////////

    // CPU held a little longer so the chipset is settled first
    always_ff @(posedge clk_chipset or posedge reset_system)
    begin
        if (reset_system)
        begin
            reset_cpu       <= 1'b1;
            cpu_delay_count <= '0;
        end
        else if (reset_cpu)
        begin
            if (cpu_delay_count != DELAY_BITS'(`PCXT_CPU_RESET_DELAY - 1))
                cpu_delay_count <= cpu_delay_count + DELAY_BITS'(1);
            else
                reset_cpu <= 1'b0;
        end
    end

    // model choice only changes through a reset
    always_ff @(posedge clk_chipset or posedge reset)
    begin
        if (reset)
            tandy_mode <= 1'b0;
        else if (reset_system)
            tandy_mode <= model_tandy;
    end

endmodule
